// ==== hdl/xbar_pkg.sv ====
/*
 * crossbar package
 * sizes, command and port-state enums, request and response structs
 * shared by every block of the four-by-four crossbar
 */

package xbar_pkg;

	localparam int NUM_MASTERS = 4;
	localparam int NUM_SLAVES  = 4;
	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;

	// slave select sits in addr[31:30]
	localparam int SEL_W       = 2;
	localparam int M_IDX_W     = 2;

	// pending reads tracked per slave port
	localparam int OWNER_DEPTH = 4;

	typedef enum logic
	{
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} xbar_cmd_e;

	// master to slave payload, 65 bits
	typedef struct packed
	{
		xbar_cmd_e           cmd;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   wdata;
	} xbar_req_t;

	typedef struct packed
	{
		logic [DATA_W-1:0]   rdata;
	} xbar_resp_t;

	typedef enum logic
	{
		SP_IDLE = 1'b0,
		SP_BUSY = 1'b1
	} port_state_e;

endpackage

// ==== hdl/xbar_addr_decode.sv ====
/*
 * address decoder
 * routes each master request to the row of its selected slave and
 * holds back a master that would switch slaves with reads outstanding
 */

`timescale 1ns/1ps

module xbar_addr_decode
(
	input  logic                                                  memread_grant,
	input  logic                                                  rst_n_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                      m_req_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0][xbar_pkg::SEL_W-1:0] m_addr_sel_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                      m_is_read_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                      m_ack_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                      m_resp_i,
	output logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::NUM_MASTERS-1:0] slv_req_o
);

	import xbar_pkg::*;

	// outstanding reads per master and the slave they went to
	logic [NUM_MASTERS-1:0][$clog2(OWNER_DEPTH+1)-1:0] pend_cnt;
	logic [NUM_MASTERS-1:0][SEL_W-1:0]                 pend_sel;
	logic [NUM_MASTERS-1:0]                            blocked;
	logic [NUM_MASTERS-1:0]                            rd_acked;

	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			blocked[m]  = (pend_cnt[m] != '0) && (pend_sel[m] != m_addr_sel_i[m]);
			rd_acked[m] = m_ack_i[m] && m_is_read_i[m];
		end
	end

	always_comb
	begin
		slv_req_o = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
			for (int s = 0; s < NUM_SLAVES; s++)
				if (m_req_i[m] && !blocked[m] && m_addr_sel_i[m] == SEL_W'(s))
					slv_req_o[s][m] = 1'b1;
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pend_cnt <= '0;
			pend_sel <= '0;
		end
		else
		begin
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				// ack and response in the same cycle cancel out
				if (rd_acked[m] && !m_resp_i[m])
					pend_cnt[m] <= pend_cnt[m] + 1'b1;
				else if (m_resp_i[m] && !rd_acked[m])
					pend_cnt[m] <= pend_cnt[m] - 1'b1;
				if (rd_acked[m])
					pend_sel[m] <= m_addr_sel_i[m];
			end
		end
	end

	// a response must match a read this decoder counted
	for (genvar g = 0; g < NUM_MASTERS; g++)
	begin : g_chk
		a_pend_no_underflow: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
			m_resp_i[g] |-> (pend_cnt[g] != '0 || rd_acked[g]));
	end

endmodule

// ==== hdl/xbar_slave_port.sv ====
/*
 * slave port
 * round-robin arbiter over the masters, payload mux, ack return
 * and a queue of owners for reads still waiting on their response
 */

`timescale 1ns/1ps

module xbar_slave_port
(
	input  logic                                               memread_grant,
	input  logic                                               rst_n_i,
	input  logic [xbar_pkg::NUM_MASTERS-1:0]                   req_vec_i,
	input  xbar_pkg::xbar_req_t [xbar_pkg::NUM_MASTERS-1:0]    m_req_i,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                   ack_vec_o,
	output logic                                               s_req_o,
	output xbar_pkg::xbar_req_t                                s_req_o_data,
	input  logic                                               s_ack_i,
	input  logic                                               s_resp_i,
	output logic [xbar_pkg::M_IDX_W-1:0]                       owner_head_o
);

	import xbar_pkg::*;

	port_state_e                 state;
	logic [NUM_MASTERS-1:0]      grant;
	logic [M_IDX_W-1:0]          grant_idx;
	logic [M_IDX_W-1:0]          rr_ptr;

	logic [NUM_MASTERS-1:0]      req_ok;
	logic                        pick_vld;
	logic [M_IDX_W-1:0]          pick_idx;
	logic [M_IDX_W-1:0]          cand;

	// owner queue
	logic [M_IDX_W-1:0]                    owner_q [OWNER_DEPTH];
	logic [$clog2(OWNER_DEPTH)-1:0]        wr_ptr;
	logic [$clog2(OWNER_DEPTH)-1:0]        rd_ptr;
	logic [$clog2(OWNER_DEPTH+1)-1:0]      q_cnt;
	logic                                  q_full;
	logic                                  push;
	logic                                  pop;

	assign q_full = (q_cnt == OWNER_DEPTH);

	// a read cannot be granted without a free owner slot
	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
			req_ok[m] = req_vec_i[m] && !(m_req_i[m].cmd == CMD_READ && q_full);
	end

	// first eligible master after the last winner
	always_comb
	begin
		pick_vld = 1'b0;
		pick_idx = '0;
		cand     = '0;
		for (int i = 1; i <= NUM_MASTERS; i++)
		begin
			cand = M_IDX_W'(int'(rr_ptr) + i);
			if (!pick_vld && req_ok[cand])
			begin
				pick_vld = 1'b1;
				pick_idx = cand;
			end
		end
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state     <= SP_IDLE;
			grant     <= '0;
			grant_idx <= '0;
			rr_ptr    <= M_IDX_W'(NUM_MASTERS - 1);
		end
		else
		begin
			case (state)
				SP_IDLE:
				begin
					if (pick_vld)
					begin
						state     <= SP_BUSY;
						grant     <= NUM_MASTERS'(1) << pick_idx;
						grant_idx <= pick_idx;
					end
				end
				SP_BUSY:
				begin
					if (s_ack_i)
					begin
						state  <= SP_IDLE;
						grant  <= '0;
						rr_ptr <= grant_idx;
					end
				end
				default: state <= SP_IDLE;
			endcase
		end
	end

	assign s_req_o      = (state == SP_BUSY);
	assign s_req_o_data = m_req_i[grant_idx];
	// slave ack goes straight back to the winner
	assign ack_vec_o    = grant & {NUM_MASTERS{s_ack_i}};

	assign push = s_req_o && s_ack_i && (s_req_o_data.cmd == CMD_READ);
	assign pop  = s_resp_i;

	always_ff @(posedge memread_grant)
	begin
		if (push)
			owner_q[wr_ptr] <= grant_idx;
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   q_cnt <= q_cnt + 1'b1;
				2'b01:   q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
		end
	end

	assign owner_head_o = owner_q[rd_ptr];

	// one winner that keeps its request until it is acked
	a_grant_onehot: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(state == SP_BUSY) |-> ($onehot(grant) && |(grant & req_vec_i)));

	a_owner_no_overflow: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		push |-> (!q_full || pop));

	// the slave must not answer more reads than were accepted
	a_owner_no_underflow: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		pop |-> (q_cnt != '0));

endmodule

// ==== hdl/xbar_resp_route.sv ====
/*
 * response router
 * steers each slave's read response to the master at the head
 * of that slave's owner queue
 */

`timescale 1ns/1ps

module xbar_resp_route
(
	input  logic                                                  memread_grant,
	input  logic                                                  rst_n_i,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                       s_resp_i,
	input  xbar_pkg::xbar_resp_t [xbar_pkg::NUM_SLAVES-1:0]       s_rdata_i,
	input  logic [xbar_pkg::NUM_SLAVES-1:0][xbar_pkg::M_IDX_W-1:0] owner_head_i,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                      m_resp_o,
	output xbar_pkg::xbar_resp_t [xbar_pkg::NUM_MASTERS-1:0]      m_rdata_o
);

	import xbar_pkg::*;

	// hit[m][s] marks a response from slave s owned by master m
	logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0] hit;

	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
			for (int s = 0; s < NUM_SLAVES; s++)
				hit[m][s] = s_resp_i[s] && (owner_head_i[s] == M_IDX_W'(m));
	end

	always_comb
	begin
		m_rdata_o = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			m_resp_o[m] = |hit[m];
			for (int s = 0; s < NUM_SLAVES; s++)
				if (hit[m][s])
					m_rdata_o[m] = s_rdata_i[s];
		end
	end

	// decoder slave lock keeps each master on one slave
	for (genvar g = 0; g < NUM_MASTERS; g++)
	begin : g_chk
		a_single_resp: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
			$onehot0(hit[g]));
	end

endmodule

// ==== hdl/xbar_top.sv ====
/*
 * four-master, four-slave crossbar
 * address decoder, one arbitrated port per slave, response router
 */

`timescale 1ns/1ps

module xbar_top
(
	input  logic                                              memread_grant,
	input  logic                                              rst_n_i,

	input  logic [xbar_pkg::NUM_MASTERS-1:0]                  m_req_i,
	input  xbar_pkg::xbar_req_t [xbar_pkg::NUM_MASTERS-1:0]   m_data_i,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                  m_ack_o,
	output logic [xbar_pkg::NUM_MASTERS-1:0]                  m_resp_o,
	output xbar_pkg::xbar_resp_t [xbar_pkg::NUM_MASTERS-1:0]  m_rdata_o,

	output logic [xbar_pkg::NUM_SLAVES-1:0]                   s_req_o,
	output xbar_pkg::xbar_req_t [xbar_pkg::NUM_SLAVES-1:0]    s_data_o,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                   s_ack_i,
	input  logic [xbar_pkg::NUM_SLAVES-1:0]                   s_resp_i,
	input  xbar_pkg::xbar_resp_t [xbar_pkg::NUM_SLAVES-1:0]   s_rdata_i
);

	import xbar_pkg::*;

	logic [NUM_MASTERS-1:0][SEL_W-1:0]       m_addr_sel;
	logic [NUM_MASTERS-1:0]                  m_is_read;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  slv_req;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  slv_ack;
	logic [NUM_SLAVES-1:0][M_IDX_W-1:0]      owner_head;

	always_comb
	begin
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			m_addr_sel[m] = m_data_i[m].addr[ADDR_W-1 -: SEL_W];
			m_is_read[m]  = (m_data_i[m].cmd == CMD_READ);
		end
	end

	// a master targets one slave, so at most one row acks it
	always_comb
	begin
		m_ack_o = '0;
		for (int s = 0; s < NUM_SLAVES; s++)
			m_ack_o = m_ack_o | slv_ack[s];
	end

	xbar_addr_decode u_decode
	(
		.memread_grant (memread_grant),
		.rst_n_i       (rst_n_i),
		.m_req_i       (m_req_i),
		.m_addr_sel_i  (m_addr_sel),
		.m_is_read_i   (m_is_read),
		.m_ack_i       (m_ack_o),
		.m_resp_i      (m_resp_o),
		.slv_req_o     (slv_req)
	);

	for (genvar s = 0; s < NUM_SLAVES; s++)
	begin : g_port
		xbar_slave_port u_port
		(
			.memread_grant (memread_grant),
			.rst_n_i       (rst_n_i),
			.req_vec_i     (slv_req[s]),
			.m_req_i       (m_data_i),
			.ack_vec_o     (slv_ack[s]),
			.s_req_o       (s_req_o[s]),
			.s_req_o_data  (s_data_o[s]),
			.s_ack_i       (s_ack_i[s]),
			.s_resp_i      (s_resp_i[s]),
			.owner_head_o  (owner_head[s])
		);
	end

	xbar_resp_route u_route
	(
		.memread_grant (memread_grant),
		.rst_n_i       (rst_n_i),
		.s_resp_i      (s_resp_i),
		.s_rdata_i     (s_rdata_i),
		.owner_head_i  (owner_head),
		.m_resp_o      (m_resp_o),
		.m_rdata_o     (m_rdata_o)
	);

endmodule

// ==== sim/slave_mem_model.sv ====
/*
 * slave memory model
 * 256-word memory preset to slave base plus byte address,
 * random ack and response delays, reads answered in order
 */

`timescale 1ns/1ps

module slave_mem_model
#(
	parameter int          SLV_IDX = 0,
	parameter logic [31:0] SEED    = 32'hb58e_b0e4
)
(
	input  logic                 memread_grant,
	input  logic                 rst_n_i,
	input  logic                 req_i,
	input  xbar_pkg::xbar_req_t  data_i,
	output logic                 ack_o,
	output logic                 resp_o,
	output xbar_pkg::xbar_resp_t rdata_o
);

	import xbar_pkg::*;

	localparam int MEM_WORDS = 256;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] rd_q [$];
	logic [31:0] rng;
	int          ack_cnt;
	int          resp_cnt;
	bit          ack_armed;
	bit          resp_armed;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {2'(SLV_IDX), 30'd0} + 32'(i * 4);
		rng        = SEED;
		ack_o      = 1'b0;
		resp_o     = 1'b0;
		rdata_o    = '0;
		ack_armed  = 1'b0;
		resp_armed = 1'b0;
	end

	// accepted transfer: write lands now, read data is queued
	always @(posedge memread_grant)
	begin
		if (rst_n_i && req_i && ack_o)
		begin
			if (data_i.cmd == CMD_WRITE)
				mem[data_i.addr[9:2]] = data_i.wdata;
			else
				rd_q.push_back(mem[data_i.addr[9:2]]);
		end
	end

	always @(negedge memread_grant)
	begin
		resp_o = 1'b0;
		if (!rst_n_i)
		begin
			ack_o = 1'b0;
			rd_q.delete();
		end
		else
		begin
			// ack high at the last edge means the request went through
			if (ack_o)
				ack_o = 1'b0;
			else if (req_i)
			begin
				if (!ack_armed)
				begin
					rng       = lcg_step(rng);
					ack_cnt   = int'(rng[17:16]);
					ack_armed = 1'b1;
				end
				if (ack_cnt == 0)
				begin
					ack_o     = 1'b1;
					ack_armed = 1'b0;
				end
				else
					ack_cnt--;
			end
			if (rd_q.size() > 0)
			begin
				if (!resp_armed)
				begin
					rng        = lcg_step(rng);
					resp_cnt   = int'(rng[21:20]);
					resp_armed = 1'b1;
				end
				if (resp_cnt == 0)
				begin
					resp_o        = 1'b1;
					rdata_o.rdata = rd_q.pop_front();
					resp_armed    = 1'b0;
				end
				else
					resp_cnt--;
			end
		end
	end

endmodule

// ==== sim/xbar_tb.sv ====
/*
 * crossbar testbench
 * four masters driven by tasks, four memory models on the slave side,
 * scoreboard memories and directed tests
 */

`timescale 1ns/1ps

module xbar_tb;

	import xbar_pkg::*;

	localparam logic [31:0] RAND_SEED = 32'hb58e_b0e4;
	localparam int          MEM_WORDS = 256;
	localparam int          RAND_OPS  = 100;
	// about 440 transfers, each well under 40 cycles even when all masters collide
	localparam int          TIMEOUT_CYCLES = 20000;

	logic                                memread_grant;
	logic                                rst_n_i;
	logic [NUM_MASTERS-1:0]              m_req;
	xbar_req_t [NUM_MASTERS-1:0]         m_data;
	logic [NUM_MASTERS-1:0]              m_ack;
	logic [NUM_MASTERS-1:0]              m_resp;
	xbar_resp_t [NUM_MASTERS-1:0]        m_rdata;
	logic [NUM_SLAVES-1:0]               s_req;
	xbar_req_t [NUM_SLAVES-1:0]          s_data;
	logic [NUM_SLAVES-1:0]               s_ack;
	logic [NUM_SLAVES-1:0]               s_resp;
	xbar_resp_t [NUM_SLAVES-1:0]         s_rdata;

	logic [31:0] sb [NUM_SLAVES][MEM_WORDS];
	logic [31:0] rng_state;
	int          cycles;
	int          rd_pend [NUM_MASTERS];
	bit          log_acks;
	int          ack_log [$];

	// random traffic, generated up front so every run is identical
	bit          op_wr   [NUM_MASTERS][RAND_OPS];
	int          op_slv  [NUM_MASTERS][RAND_OPS];
	int          op_idx  [NUM_MASTERS][RAND_OPS];
	logic [31:0] op_data [NUM_MASTERS][RAND_OPS];

	xbar_top dut
	(
		.memread_grant (memread_grant),
		.rst_n_i       (rst_n_i),
		.m_req_i       (m_req),
		.m_data_i      (m_data),
		.m_ack_o       (m_ack),
		.m_resp_o      (m_resp),
		.m_rdata_o     (m_rdata),
		.s_req_o       (s_req),
		.s_data_o      (s_data),
		.s_ack_i       (s_ack),
		.s_resp_i      (s_resp),
		.s_rdata_i     (s_rdata)
	);

	for (genvar s = 0; s < NUM_SLAVES; s++)
	begin : g_mem
		slave_mem_model #(.SLV_IDX(s), .SEED(RAND_SEED + 32'(s))) u_mem
		(
			.memread_grant (memread_grant),
			.rst_n_i       (rst_n_i),
			.req_i         (s_req[s]),
			.data_i        (s_data[s]),
			.ack_o         (s_ack[s]),
			.resp_o        (s_resp[s]),
			.rdata_o       (s_rdata[s])
		);
	end

	initial
	begin
		memread_grant = 1'b0;
		forever #4 memread_grant = ~memread_grant;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] make_addr(input int s, input int idx);
		return {2'(s), 20'd0, 8'(idx), 2'b00};
	endfunction

	// preset contents: slave number in the top bits plus the byte address
	function automatic logic [31:0] preset_word(input int s, input int idx);
		return {2'(s), 30'd0} + 32'(idx * 4);
	endfunction

	task automatic fail_stop();
		$display("Checks failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("Error: %s", what);
			fail_stop();
		end
	endtask

	// timeout, ack order log, slave select of each request
	// and a check that responses only reach waiting masters
	always @(posedge memread_grant)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
			fail_stop();
		end
		else if (rst_n_i)
		begin
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				if (m_resp[m])
				begin
					check_true(rd_pend[m] > 0, "a response reached a master with no read outstanding");
					rd_pend[m]--;
				end
				if (m_ack[m] && m_data[m].cmd == CMD_READ)
					rd_pend[m]++;
				if (log_acks && m_ack[m])
					ack_log.push_back(m);
			end
			for (int s = 0; s < NUM_SLAVES; s++)
				if (s_req[s])
					check_true(s_data[s].addr[31:30] == 2'(s),
						"a request reached a slave its address does not select");
		end
	end

	task automatic issue_req(input int m, input xbar_cmd_e cmd, input logic [31:0] addr,
		input logic [31:0] wdata);
		@(negedge memread_grant);
		m_data[m] = '{cmd: cmd, addr: addr, wdata: wdata};
		m_req[m]  = 1'b1;
		do
			@(posedge memread_grant);
		while (!m_ack[m]);
		@(negedge memread_grant);
		m_req[m] = 1'b0;
	endtask

	task automatic wait_resp(input int m, output logic [31:0] data);
		do
			@(posedge memread_grant);
		while (!m_resp[m]);
		data = m_rdata[m].rdata;
	endtask

	task automatic do_write(input int m, input int s, input int idx, input logic [31:0] data);
		issue_req(m, CMD_WRITE, make_addr(s, idx), data);
		sb[s][idx] = data;
	endtask

	task automatic do_read(input int m, input int s, input int idx, output logic [31:0] data);
		issue_req(m, CMD_READ, make_addr(s, idx), 32'd0);
		wait_resp(m, data);
	endtask

	task automatic reset_check();
		rst_n_i = 1'b0;
		repeat (16)
		begin
			@(negedge memread_grant);
			check_true(m_ack == '0 && m_resp == '0 && s_req == '0, "outputs not low in reset");
		end
		rst_n_i = 1'b1;
		repeat (3)
		begin
			@(negedge memread_grant);
			check_true(m_ack == '0 && m_resp == '0 && s_req == '0, "outputs not low after reset");
		end
	endtask

	task automatic write_read_each_slave();
		logic [31:0] wdata;
		logic [31:0] rd;
		for (int s = 0; s < NUM_SLAVES; s++)
		begin
			wdata = 32'ha500_0000 | (32'(s) << 8) | 32'(8'h10 + s);
			do_write(0, s, 8'h10 + s, wdata);
			do_read(0, s, 8'h10 + s, rd);
			check_value("write_read_each_slave", wdata, rd);
			do_read(0, s, 8'hf0, rd);
			check_value("write_read_each_slave untouched", preset_word(s, 8'hf0), rd);
		end
	endtask

	task automatic read_twice_slave2(input int m);
		logic [31:0] rd;
		do_read(m, 2, 8'h40 + m, rd);
		check_value("contention_one_slave", sb[2][8'h40 + m], rd);
		do_read(m, 2, 8'h44 + m, rd);
		check_value("contention_one_slave", sb[2][8'h44 + m], rd);
	endtask

	task automatic contention_one_slave();
		logic [3:0] seen;
		ack_log.delete();
		log_acks = 1'b1;
		fork
			read_twice_slave2(0);
			read_twice_slave2(1);
			read_twice_slave2(2);
			read_twice_slave2(3);
		join
		log_acks = 1'b0;
		check_value("contention_one_slave ack count", 32'd8, 32'(ack_log.size()));
		// each group of four acks must cover every master once
		for (int r = 0; r < 2; r++)
		begin
			seen = '0;
			for (int k = 0; k < 4; k++)
				seen[ack_log[r * 4 + k]] = 1'b1;
			check_value("contention_one_slave ack round", 32'hf, 32'(seen));
		end
	endtask

	task automatic read_own_slave(input int m);
		logic [31:0] rd;
		for (int k = 0; k < 3; k++)
		begin
			do_read(m, m, 8'h80 + 4 * k + m, rd);
			check_value("parallel_slaves", sb[m][8'h80 + 4 * k + m], rd);
		end
	endtask

	task automatic parallel_slaves();
		fork
			read_own_slave(0);
			read_own_slave(1);
			read_own_slave(2);
			read_own_slave(3);
		join
	endtask

	task automatic pipelined_reads();
		logic [31:0] got [$];
		logic [31:0] rd;
		fork
			for (int k = 0; k < 4; k++)
				issue_req(1, CMD_READ, make_addr(3, 8'h60 + k), 32'd0);
			for (int k = 0; k < 4; k++)
			begin
				wait_resp(1, rd);
				got.push_back(rd);
			end
		join
		for (int k = 0; k < 4; k++)
			check_value("pipelined_reads", sb[3][8'h60 + k], got[k]);
	endtask

	// each master only touches words whose index is its own number mod 4
	task automatic run_random(input int m);
		logic [31:0] rd;
		for (int i = 0; i < RAND_OPS; i++)
		begin
			if (op_wr[m][i])
				do_write(m, op_slv[m][i], op_idx[m][i], op_data[m][i]);
			else
			begin
				do_read(m, op_slv[m][i], op_idx[m][i], rd);
				check_value("random_traffic", sb[op_slv[m][i]][op_idx[m][i]], rd);
			end
		end
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		for (int m = 0; m < NUM_MASTERS; m++)
			for (int i = 0; i < RAND_OPS; i++)
			begin
				r             = next_rand();
				op_wr[m][i]   = r[31];
				op_slv[m][i]  = int'(r[29:28]);
				op_idx[m][i]  = int'({r[21:16], 2'(m)});
				op_data[m][i] = next_rand();
			end
		fork
			run_random(0);
			run_random(1);
			run_random(2);
			run_random(3);
		join
	endtask

	initial
	begin
		rst_n_i   = 1'b0;
		m_req     = '0;
		m_data    = '0;
		cycles    = 0;
		log_acks  = 1'b0;
		rng_state = RAND_SEED;
		for (int m = 0; m < NUM_MASTERS; m++)
			rd_pend[m] = 0;
		for (int s = 0; s < NUM_SLAVES; s++)
			for (int i = 0; i < MEM_WORDS; i++)
				sb[s][i] = preset_word(s, i);

		reset_check();
		write_read_each_slave();
		contention_one_slave();
		parallel_slaves();
		pipelined_reads();
		random_traffic();
		repeat (4) @(negedge memread_grant);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/xbar_pkg.sv
hdl/xbar_addr_decode.sv
hdl/xbar_slave_port.sv
hdl/xbar_resp_route.sv
hdl/xbar_top.sv
sim/slave_mem_model.sv
sim/xbar_tb.sv

// ==== Makefile ====
# Verilator flow for the crossbar testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= xbar_tb
DUT_TOP    ?= xbar_top
FLIST      ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All checks passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
